// File: common/rmw_pkg.sv
// RMW engine shared definitions
package rmw_pkg;

    localparam int DATA_WIDTH = 16;     // RAM word and operand width
    localparam int ADDR_WIDTH = 10;
    localparam int MEM_DEPTH  = 1024;

    // top word has no partner at addr + 1
    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(MEM_DEPTH - 1);

    typedef enum logic [1:0] {
        OP_READ  = 2'd0,                // return the pair unchanged
        OP_WRITE = 2'd1,                // operand into both words
        OP_ADD   = 2'd2,
        OP_SUB   = 2'd3
    } rmw_op_e;

    typedef enum logic [1:0] {
        ST_OK       = 2'd0,
        ST_ADDR_ERR = 2'd1              // base address out of range
    } rmw_status_e;

    typedef enum logic [2:0] {
        S_IDLE  = 3'd0,
        S_ADDR  = 3'd1,                 // addresses presented to the RAM
        S_DATA  = 3'd2,                 // read data back, modify
        S_WRITE = 3'd3,
        S_DONE  = 3'd4
    } exec_state_e;

    // host command, 28 bits
    typedef struct packed {
        rmw_op_e               op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] operand;
    } rmw_cmd_t;

    // host response, 34 bits
    typedef struct packed {
        rmw_status_e           status;
        logic [DATA_WIDTH-1:0] data_a;  // word at addr
        logic [DATA_WIDTH-1:0] data_b;  // word at addr + 1
    } rmw_rsp_t;

    // decoded operation, both port addresses already resolved
    typedef struct packed {
        rmw_op_e               op;
        logic [ADDR_WIDTH-1:0] addr_a;
        logic [ADDR_WIDTH-1:0] addr_b;
        logic [DATA_WIDTH-1:0] operand;
    } exec_op_t;

endpackage

// File: rmw_engine/dp_ram.sv
// True dual-port single-clock RAM
`timescale 1ns/100ps

module dp_ram import rmw_pkg::*; (
    input  logic                  clk,
    input  logic [ADDR_WIDTH-1:0] addr_a,
    input  logic [ADDR_WIDTH-1:0] addr_b,
    input  logic [DATA_WIDTH-1:0] data_a,
    input  logic [DATA_WIDTH-1:0] data_b,
    input  logic                  we_a,
    input  logic                  we_b,
    output logic [DATA_WIDTH-1:0] q_a,
    output logic [DATA_WIDTH-1:0] q_b
);

    logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

    // RAM powers up cleared
    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // port b wins if both ports write one address
    always @(posedge clk) begin
        if (we_a) begin
            mem[addr_a] <= data_a;
        end
        if (we_b) begin
            mem[addr_b] <= data_b;
        end
    end

    // registered read, a writing port returns the new word
    always_ff @(posedge clk) begin
        q_a <= we_a ? data_a : mem[addr_a];
        q_b <= we_b ? data_b : mem[addr_b];
    end

endmodule

// File: rmw_engine/rmw_execute.sv
// Word pair read-modify-write sequencer
`timescale 1ns/100ps

module rmw_execute import rmw_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  exec_op_t              exec_op,
    input  logic                  exec_valid,
    input  logic [DATA_WIDTH-1:0] q_a,
    input  logic [DATA_WIDTH-1:0] q_b,
    output logic [ADDR_WIDTH-1:0] addr_a,
    output logic [ADDR_WIDTH-1:0] addr_b,
    output logic [DATA_WIDTH-1:0] data_a,
    output logic [DATA_WIDTH-1:0] data_b,
    output logic                  we_a,
    output logic                  we_b,
    output rmw_rsp_t              exec_rsp,
    output logic                  exec_done
);

    exec_state_e           state;
    exec_state_e           state_next;
    exec_op_t              op_q;        // held for the whole sequence
    logic [DATA_WIDTH-1:0] word_a;      // modified word, port a
    logic [DATA_WIDTH-1:0] word_b;      // modified word, port b
    logic [DATA_WIDTH-1:0] new_a;
    logic [DATA_WIDTH-1:0] new_b;

    // apply one opcode to one word, sums wrap at DATA_WIDTH
    function automatic logic [DATA_WIDTH-1:0] modify(
        input rmw_op_e               op,
        input logic [DATA_WIDTH-1:0] word,
        input logic [DATA_WIDTH-1:0] operand
    );
        case (op)
            OP_WRITE: return operand;
            OP_ADD:   return word + operand;
            OP_SUB:   return word - operand;
            default:  return word;          // read keeps the word
        endcase
    endfunction

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (exec_valid) begin
                    state_next = S_ADDR;
                end
            end
            S_ADDR: begin
                state_next = S_DATA;            // RAM registers read data
            end
            S_DATA: begin
                if (op_q.op == OP_READ) begin
                    state_next = S_DONE;        // nothing to write back
                end else begin
                    state_next = S_WRITE;
                end
            end
            S_WRITE: begin
                state_next = S_DONE;
            end
            S_DONE: begin
                state_next = S_IDLE;
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // operation latched once per command
    always_ff @(posedge clk) begin
        if (state == S_IDLE && exec_valid) begin
            op_q <= exec_op;
        end
    end

    assign new_a = modify(op_q.op, q_a, op_q.operand);
    assign new_b = modify(op_q.op, q_b, op_q.operand);

    // q is valid in S_DATA, one cycle after S_ADDR
    always_ff @(posedge clk) begin
        if (state == S_DATA) begin
            word_a <= new_a;
            word_b <= new_b;
        end
    end

    assign addr_a = op_q.addr_a;
    assign addr_b = op_q.addr_b;
    assign data_a = word_a;
    assign data_b = word_b;

    // both ports written in the same cycle
    assign we_a = (state == S_WRITE);
    assign we_b = (state == S_WRITE);

    assign exec_done = (state == S_DONE);
    assign exec_rsp  = '{status: ST_OK, data_a: word_a, data_b: word_b};

endmodule

// File: design/cmd_decode.sv
// Command decode and address check
`timescale 1ns/100ps

module cmd_decode import rmw_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     req,
    input  logic     ack,
    input  rmw_cmd_t cmd,
    output exec_op_t exec_op,
    output logic     exec_valid,
    output logic     err_valid
);

    logic busy;         // handshake in progress
    logic accept;       // new command this cycle
    logic taken;        // command latched on the last edge
    logic addr_ok;      // base has a partner word

    assign accept = req && !busy;

    // busy from accept until req and ack are both low
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (!req && !ack) begin
            busy <= 1'b0;
        end
    end

    // resolve both port addresses once, on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            exec_op.op      <= cmd.op;
            exec_op.addr_a  <= cmd.addr;
            exec_op.addr_b  <= cmd.addr + ADDR_WIDTH'(1);
            exec_op.operand <= cmd.operand;
            addr_ok         <= (cmd.addr < LAST_ADDR);
        end
    end

    // one-cycle issue pulse, either to execute or to the error path
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            taken      <= 1'b0;
            exec_valid <= 1'b0;
            err_valid  <= 1'b0;
        end else begin
            taken      <= accept;
            exec_valid <= taken && addr_ok;
            err_valid  <= taken && !addr_ok;
        end
    end

endmodule

// File: design/rsp_result.sv
// Response capture and host ack
`timescale 1ns/100ps

module rsp_result import rmw_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     req,
    input  rmw_rsp_t exec_rsp,
    input  logic     exec_done,
    input  logic     err_valid,
    output rmw_rsp_t rsp,
    output logic     ack
);

    // held until the next command completes
    always_ff @(posedge clk) begin
        if (exec_done) begin
            rsp <= exec_rsp;
        end else if (err_valid) begin
            rsp <= '{status: ST_ADDR_ERR, data_a: '0, data_b: '0};  // rejected, no data
        end
    end

    // up on capture, down once req is seen low
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ack <= 1'b0;
        end else if (exec_done || err_valid) begin
            ack <= 1'b1;
        end else if (ack && !req) begin
            ack <= 1'b0;
        end
    end

endmodule

// File: design/rmw_top.sv
// RMW engine top level
`timescale 1ns/100ps

module rmw_top import rmw_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     req,
    input  rmw_cmd_t cmd,
    output logic     ack,
    output rmw_rsp_t rsp
);

    exec_op_t              exec_op;
    logic                  exec_valid;
    logic                  err_valid;
    logic [ADDR_WIDTH-1:0] addr_a;
    logic [ADDR_WIDTH-1:0] addr_b;
    logic [DATA_WIDTH-1:0] data_a;
    logic [DATA_WIDTH-1:0] data_b;
    logic                  we_a;
    logic                  we_b;
    logic [DATA_WIDTH-1:0] q_a;
    logic [DATA_WIDTH-1:0] q_b;
    rmw_rsp_t              exec_rsp;
    logic                  exec_done;

    cmd_decode u_cmd_decode (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .ack        (ack),          // same net as the host port
        .cmd        (cmd),
        .exec_op    (exec_op),
        .exec_valid (exec_valid),
        .err_valid  (err_valid)
    );

    rmw_execute u_rmw_execute (
        .clk        (clk),
        .reset      (reset),
        .exec_op    (exec_op),
        .exec_valid (exec_valid),
        .q_a        (q_a),
        .q_b        (q_b),
        .addr_a     (addr_a),
        .addr_b     (addr_b),
        .data_a     (data_a),
        .data_b     (data_b),
        .we_a       (we_a),
        .we_b       (we_b),
        .exec_rsp   (exec_rsp),
        .exec_done  (exec_done)
    );

    dp_ram u_dp_ram (
        .clk    (clk),
        .addr_a (addr_a),
        .addr_b (addr_b),
        .data_a (data_a),
        .data_b (data_b),
        .we_a   (we_a),
        .we_b   (we_b),
        .q_a    (q_a),
        .q_b    (q_b)
    );

    rsp_result u_rsp_result (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .exec_rsp  (exec_rsp),
        .exec_done (exec_done),
        .err_valid (err_valid),
        .rsp       (rsp),
        .ack       (ack)
    );

endmodule

// File: sim/rmw_tb.sv
// RMW engine testbench
`timescale 1ns/100ps

module rmw_tb import rmw_pkg::*; ();

    logic     clk;
    logic     reset;
    logic     req;
    rmw_cmd_t cmd;
    logic     ack;
    rmw_rsp_t rsp;

    logic [DATA_WIDTH-1:0] ref_mem [MEM_DEPTH];    // expected RAM contents
    logic [31:0]           lfsr_state;
    logic                  hung;                   // DUT stopped answering
    int                    errors;
    int                    checks;
    int                    tests;

    rmw_top DUT (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .cmd   (cmd),
        .ack   (ack),
        .rsp   (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // 32-bit Galois LFSR, right shifting
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // base address with a partner word, low bit forced
    function automatic logic [ADDR_WIDTH-1:0] rand_addr(input logic odd);
        logic [ADDR_WIDTH-1:0] a;
        a = ADDR_WIDTH'(rand_bits(ADDR_WIDTH));
        a[0] = odd;
        if (a == LAST_ADDR) begin
            a = LAST_ADDR - ADDR_WIDTH'(2);
        end
        return a;
    endfunction

    // word after one command, sums wrap at 16 bits
    function automatic logic [DATA_WIDTH-1:0] expect_word(input rmw_op_e code,
            input logic [DATA_WIDTH-1:0] w, input logic [DATA_WIDTH-1:0] x);
        logic [DATA_WIDTH-1:0] r;
        r = w;
        if (code == OP_WRITE) r = x;
        if (code == OP_ADD) r = w + x;
        if (code == OP_SUB) r = w - x;
        return r;
    endfunction

    task automatic check_status(input rmw_status_e got, input rmw_status_e exp,
                                input string what);
        if (!hung) begin
            checks++;
            if (got !== exp) begin
                errors++;
                $display("FAILED at %0t: %s, status %s, expected %s",
                         $time, what, got.name(), exp.name());
            end
        end
    endtask

    task automatic check_words(input rmw_rsp_t got, input rmw_rsp_t exp, input string what);
        if (!hung) begin
            checks++;
            if (got.data_a !== exp.data_a || got.data_b !== exp.data_b) begin
                errors++;
                $display("FAILED at %0t: %s, words %h %h, expected %h %h",
                         $time, what, got.data_a, got.data_b, exp.data_a, exp.data_b);
            end
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // one four-phase transaction, req held for hold cycles after ack
    task automatic do_cmd(input rmw_cmd_t c, input rmw_rsp_t exp, input int hold,
                          output rmw_rsp_t got);
        int cycles;
        got = '0;
        if (hung) return;
        @(negedge clk);
        cmd = c;
        req = 1'b1;
        cycles = 0;
        while (!ack && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (!ack) begin
            $display("timeout at %0t: ack never rose for %s at address %0d",
                     $time, c.op.name(), c.addr);
            hung = 1'b1;
            req = 1'b0;
            return;
        end
        got = rsp;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_level(ack, 1'b1, "ack under back-pressure");
            check_status(rsp.status, exp.status, "held rsp");
            check_words(rsp, exp, "held rsp");
        end
        req = 1'b0;
        cycles = 0;
        while (ack && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (ack) begin
            $display("timeout at %0t: ack stayed high after req dropped", $time);
            hung = 1'b1;
            return;
        end
        @(negedge clk);                     // idle cycle so decode sees req and ack low
    endtask

    // runs one command against the model and checks the response
    task automatic run_op(input rmw_op_e code, input logic [ADDR_WIDTH-1:0] addr,
                          input logic [DATA_WIDTH-1:0] operand, input int hold);
        rmw_cmd_t c;
        rmw_rsp_t got;
        rmw_rsp_t exp;
        string    what;
        c = '{op: code, addr: addr, operand: operand};
        what = $sformatf("%s at %0d", code.name(), addr);
        if (addr == LAST_ADDR) begin
            exp = '{status: ST_ADDR_ERR, data_a: '0, data_b: '0};
        end else begin
            exp.status = ST_OK;
            exp.data_a = expect_word(code, ref_mem[int'(addr)], operand);
            exp.data_b = expect_word(code, ref_mem[int'(addr) + 1], operand);
            ref_mem[int'(addr)] = exp.data_a;
            ref_mem[int'(addr) + 1] = exp.data_b;
        end
        do_cmd(c, exp, hold, got);
        check_status(got.status, exp.status, what);
        check_words(got, exp, what);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (hung) begin
            $display("%s: stopped, DUT did not respond", name);
        end else if (errors == errors_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed, %0d mismatches", name, errors - errors_before);
        end
    endtask

    task automatic reset_read();
        int e0;
        e0 = errors;
        check_level(ack, 1'b0, "ack after reset");
        run_op(OP_READ, '0, '0, 0);
        report_test("reset_read", e0);
    endtask

    task automatic write_then_read();
        int                    e0;
        logic [ADDR_WIDTH-1:0] addrs [6];
        e0 = errors;
        addrs[0] = ADDR_WIDTH'(510);
        addrs[1] = ADDR_WIDTH'(512);
        for (int i = 2; i < 6; i++) begin
            addrs[i] = rand_addr(i[0]);     // alternate even and odd bases
        end
        foreach (addrs[i]) begin
            run_op(OP_WRITE, addrs[i], DATA_WIDTH'(rand_bits(DATA_WIDTH)), 0);
            run_op(OP_READ, addrs[i], '0, 0);
        end
        report_test("write_read", e0);
    endtask

    task automatic add_sub_writeback();
        int                    e0;
        logic [ADDR_WIDTH-1:0] a;
        rmw_op_e               code;
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            a = rand_addr(rand_bits(1) != 0);
            code = (rand_bits(1) != 0) ? OP_SUB : OP_ADD;
            run_op(OP_WRITE, a, DATA_WIDTH'(rand_bits(DATA_WIDTH)), 0);
            run_op(code, a, DATA_WIDTH'(rand_bits(DATA_WIDTH)), 0);
            run_op(OP_READ, a, '0, 0);
        end
        report_test("add_sub", e0);
    endtask

    task automatic overlap_pairs();
        int                    e0;
        logic [ADDR_WIDTH-1:0] n;
        e0 = errors;
        n = rand_addr(rand_bits(1) != 0);
        if (n > ADDR_WIDTH'(1021)) begin
            n = ADDR_WIDTH'(1020);          // n + 1 must still have a partner
        end
        run_op(OP_WRITE, n, DATA_WIDTH'(rand_bits(DATA_WIDTH)), 0);
        run_op(OP_ADD, n, DATA_WIDTH'(rand_bits(DATA_WIDTH)), 0);
        run_op(OP_SUB, n + ADDR_WIDTH'(1), DATA_WIDTH'(rand_bits(DATA_WIDTH)), 0);
        run_op(OP_READ, n, '0, 0);
        run_op(OP_READ, n + ADDR_WIDTH'(1), '0, 0);
        report_test("overlap", e0);
    endtask

    task automatic addr_error();
        int e0;
        e0 = errors;
        run_op(OP_WRITE, LAST_ADDR - ADDR_WIDTH'(1), DATA_WIDTH'(rand_bits(DATA_WIDTH)), 0);
        run_op(OP_ADD, LAST_ADDR, DATA_WIDTH'(rand_bits(DATA_WIDTH)), 0);
        run_op(OP_WRITE, LAST_ADDR, DATA_WIDTH'(rand_bits(DATA_WIDTH)), 0);
        run_op(OP_READ, LAST_ADDR - ADDR_WIDTH'(1), '0, 0);
        report_test("addr_err", e0);
    endtask

    task automatic held_request();
        int                    e0;
        logic [ADDR_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] x;
        e0 = errors;
        a = rand_addr(1'b0);
        x = DATA_WIDTH'(rand_bits(DATA_WIDTH)) | DATA_WIDTH'(1);    // nonzero, a repeat shows
        run_op(OP_WRITE, a, DATA_WIDTH'(rand_bits(DATA_WIDTH)), 0);
        run_op(OP_ADD, a, x, 20);
        run_op(OP_READ, a, '0, 0);
        report_test("backpressure", e0);
    endtask

    initial begin
        reset = 1'b0;
        req = 1'b0;
        cmd = '0;
        hung = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        lfsr_state = 32'd97849;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            ref_mem[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        reset_read();
        write_then_read();
        add_sub_writeback();
        overlap_pairs();
        addr_error();
        held_request();
        $display("tests %0d, checks %0d, mismatches %0d", tests, checks, errors);
        if (hung || errors != 0) begin
            $display("ERRORS FOUND");
        end else begin
            $display("NO ERRORS");
        end
        $finish;
    end

endmodule

// File: src.f
common/rmw_pkg.sv
rmw_engine/dp_ram.sv
rmw_engine/rmw_execute.sv
design/cmd_decode.sv
design/rsp_result.sv
design/rmw_top.sv
sim/rmw_tb.sv

// File: Makefile
# Verilator build and run for the RMW engine

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = rmw_tb
FILELIST  = src.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = NO ERRORS

SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a listed source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
